// ==== files.f ====
hdl/FprPkg.sv
hdl/FprRegFile.sv
hdl/FprDecode.sv
hdl/FprExecute.sv
hdl/FprSlice.sv
tb/FprSliceTb.sv

// ==== Makefile ====
# Verilator build for the FPR slice testbench.

VERILATOR ?= verilator
TOP       ?= FprSliceTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASSED

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/FprSliceTb.sv ====
// FPR slice testbench.
// Operation streams with hold pulses run against a shadow register model;
// store outputs and the T flag are compared on every falling edge.

module FprSliceTb;

	import FprPkg::*;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 16;
	localparam int DriveDelay = 5;
	localparam int MoveOps = 24;
	localparam int DepOps = 8;
	localparam int CmpOps = 24;
	localparam int StreamOps = 120;
	localparam int FixedOps = 22; // zero register, signed zeros, idle tail.
	localparam int TotalOps = 4 * FprRegCount + 2 * MoveOps + 4 * DepOps + 2 * CmpOps
		+ StreamOps + FixedOps;
	localparam int WatchdogCycles = TotalOps * 4 + 100;

	logic                    clock;
	logic                    reset;
	logic [FprWordWidth-1:0] opWord;
	logic                    opValid;
	logic                    hold;
	logic                    storeValid;
	logic [FprDataWidth-1:0] storeData;
	logic                    tBit;

	logic [FprDataWidth-1:0] shadow [FprRegCount];
	logic                    expT;
	logic                    expStoreValid;
	logic [FprDataWidth-1:0] expStoreData;
	logic                    edgeSeen = 1'b0;
	logic                    holdAtEdge;
	int holdOdds;
	int storesIssued = 0;
	int dutStores = 0;
	int checkCount = 0;
	int errorCount = 0;
	int endErrors = 0;

	FprSlice u_FprSlice
	(
		.clock      (clock),
		.reset      (reset),
		.opWord     (opWord),
		.opValid    (opValid),
		.hold       (hold),
		.storeValid (storeValid),
		.storeData  (storeData),
		.tBit       (tBit)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(ClockPeriod / 2);
			clock = ~clock;
		end
	end

	function automatic logic [31:0] buildWord(input logic [3:0] op, input logic [6:0] dst,
		input logic [6:0] rm, input logic [6:0] rn);
		return {op, dst, rm, rn, 7'h00};
	endfunction

	function automatic logic [31:0] buildLdh(input logic [6:0] dst, input logic [15:0] imm);
		return {OpLdh, dst, imm, 5'h00};
	endfunction

	function automatic logic [6:0] anyReg();
		return {3'b000, 4'($urandom)};
	endfunction

	function automatic logic [3:0] moveOpcode();
		logic [3:0] op;

		case ($urandom % 4)
			0: op = OpMov;
			1: op = OpNeg;
			2: op = OpAbs;
			default: op = OpSgnj;
		endcase
		return op;
	endfunction

	function automatic logic holdThisCycle();
		return (holdOdds != 0) && (($urandom % holdOdds) == 0);
	endfunction

	function automatic logic [63:0] regValue(input logic [6:0] id);
		return (id == FprZeroId) ? 64'h0 : shadow[id[3:0]];
	endfunction

	// expected result of a register-writing operation.
	function automatic logic [63:0] refResult(input logic [3:0] op, input logic [63:0] a,
		input logic [63:0] b, input logic [15:0] imm);
		logic [63:0] r;

		r = a;
		case (op)
			OpNeg: r[63] = ~a[63];
			OpAbs: r[63] = 1'b0;
			OpSgnj: r[63] = b[63];
			OpLdh: r = {imm, 48'h0};
			default: r = a; // move.
		endcase
		return r;
	endfunction

	// negatives below positives, both zeros map to the same key.
	function automatic logic [63:0] orderKey(input logic [63:0] v);
		if (v[63] && (v[62:0] != '0))
			return {1'b0, ~v[62:0]};
		return {1'b1, v[62:0]};
	endfunction

	function automatic logic refCompare(input logic [3:0] op, input logic [63:0] a,
		input logic [63:0] b);
		if (op == OpCmpEq)
			return orderKey(a) == orderKey(b);
		return orderKey(a) > orderKey(b);
	endfunction

	task automatic applyOp(input logic [31:0] word);
		logic [3:0]  op;
		logic [6:0]  dst;
		logic [63:0] valRm;
		logic [63:0] valRn;

		op = word[31:28];
		dst = word[27:21];
		valRm = regValue(word[20:14]);
		valRn = regValue(word[13:7]);
		case (op)
			OpMov, OpNeg, OpAbs, OpSgnj, OpLdh:
				if (dst[6:4] == 3'b000)
					shadow[dst[3:0]] = refResult(op, valRm, valRn, word[20:5]);
			OpCmpEq, OpCmpGt:
				expT = refCompare(op, valRm, valRn);
			OpStore:
			begin
				expStoreValid = 1'b1;
				expStoreData = valRn;
			end
			default:
				; // no-op or unknown code.
		endcase
	endtask

	// reference model, follows every accepted operation.
	always @(posedge clock)
	begin
		edgeSeen = 1'b1;
		holdAtEdge = hold;
		if (reset)
		begin
			expStoreValid = 1'b0;
			expT = 1'b0;
		end
		else if (!hold)
		begin
			expStoreValid = 1'b0;
			if (opValid)
				applyOp(opWord);
		end
	end

	always @(negedge clock)
	begin
		if (edgeSeen)
		begin
			checkCount++;
			assert (storeValid === expStoreValid)
			else
			begin
				errorCount++;
				$display("ERR %0t storeValid expected %b actual %b", $time, expStoreValid,
					storeValid);
			end
			if (expStoreValid)
			begin
				assert (storeData === expStoreData)
				else
				begin
					errorCount++;
					$display("ERR %0t storeData expected %h actual %h", $time, expStoreData,
						storeData);
				end
			end
			assert (tBit === expT)
			else
			begin
				errorCount++;
				$display("ERR %0t tBit expected %b actual %b", $time, expT, tBit);
			end
			if (storeValid && !holdAtEdge)
				dutStores++; // a new store left the pipeline.
		end
	end

	task automatic issueOp(input logic [31:0] word);
		opWord = word;
		opValid = 1'b1;
		hold = holdThisCycle();
		@(posedge clock);
		while (hold)
		begin
			#DriveDelay;
			hold = holdThisCycle(); // word stays put while held.
			@(posedge clock);
		end
		#DriveDelay;
		opValid = 1'b0;
		hold = 1'b0;
		if (word[31:28] == OpStore)
			storesIssued++;
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			opValid = 1'b0;
			hold = holdThisCycle();
			@(posedge clock);
			#DriveDelay;
		end
		hold = 1'b0;
	endtask

	task automatic dumpRegs();
		for (int i = 0; i < FprRegCount; i++)
			issueOp(buildWord(OpStore, FprZeroId, FprZeroId, 7'(i)));
	endtask

	initial
	begin
		logic [6:0] a;
		logic [6:0] b;
		logic [6:0] c;
		int pick;

		void'($urandom(32'hc934));
		reset = 1'b1;
		opWord = '0;
		opValid = 1'b0;
		hold = 1'b0;
		holdOdds = 0;
		repeat (ResetCycles) @(posedge clock);
		#DriveDelay;
		reset = 1'b0;

		for (int i = 0; i < FprRegCount; i++)
			issueOp(buildLdh(7'(i), 16'($urandom)));
		dumpRegs();
		for (int i = 0; i < MoveOps; i++)
		begin
			a = anyReg();
			issueOp(buildWord(moveOpcode(), a, anyReg(), anyReg()));
			issueOp(buildWord(OpStore, FprZeroId, FprZeroId, a));
		end

		// each operation reads the register written just before it.
		for (int i = 0; i < DepOps; i++)
		begin
			a = anyReg();
			b = anyReg();
			c = anyReg();
			issueOp(buildLdh(a, 16'($urandom)));
			issueOp(buildWord(OpNeg, b, a, a));
			issueOp(buildWord(OpSgnj, c, b, a));
			issueOp(buildWord(OpStore, FprZeroId, FprZeroId, c));
		end

		repeat (4) issueOp(buildWord(OpStore, FprZeroId, anyReg(), FprZeroId));
		issueOp(buildWord(OpMov, 7'h23, anyReg(), anyReg()));
		issueOp(buildLdh(7'h10, 16'hbeef));
		issueOp(buildLdh(FprZeroId, 16'h1234));
		issueOp(buildWord(OpNop, anyReg(), anyReg(), anyReg()));
		issueOp(buildWord(4'hb, anyReg(), anyReg(), anyReg()));
		issueOp(buildWord(4'hf, anyReg(), anyReg(), anyReg()));
		opWord = buildWord(OpAbs, anyReg(), anyReg(), anyReg()); // not valid.
		idleCycles(1);
		dumpRegs();

		for (int i = 0; i < CmpOps; i++)
		begin
			a = anyReg();
			b = ($urandom % 4 == 0) ? a : anyReg();
			issueOp(buildWord(($urandom % 2 == 0) ? OpCmpEq : OpCmpGt, anyReg(), a, b));
			if ($urandom % 2 == 0)
				issueOp(buildWord(moveOpcode(), anyReg(), anyReg(), anyReg()));
		end
		issueOp(buildLdh(7'd0, 16'h0000));
		issueOp(buildLdh(7'd1, 16'h8000)); // minus zero.
		issueOp(buildWord(OpCmpEq, FprZeroId, 7'd0, 7'd1));
		issueOp(buildWord(OpCmpGt, FprZeroId, 7'd1, 7'd0));
		issueOp(buildWord(OpCmpEq, FprZeroId, 7'd1, 7'd0));
		issueOp(buildWord(OpCmpGt, FprZeroId, 7'd0, 7'd1));
		issueOp(buildWord(OpNeg, 7'd2, 7'd1, 7'd1));

		holdOdds = 4;
		for (int i = 0; i < StreamOps; i++)
		begin
			pick = $urandom % 10;
			a = ($urandom % 8 == 0) ? FprZeroId : anyReg();
			if (pick < 5)
				issueOp(buildWord(moveOpcode(), anyReg(), a, anyReg()));
			else if (pick == 5)
				issueOp(buildLdh(anyReg(), 16'($urandom)));
			else if (pick < 8)
				issueOp(buildWord((pick == 6) ? OpCmpEq : OpCmpGt, anyReg(), a, anyReg()));
			else if (pick == 8)
				issueOp(buildWord(OpStore, FprZeroId, FprZeroId, a));
			else
				idleCycles(1);
		end
		dumpRegs();
		holdOdds = 0;
		idleCycles(4);

		assert (storesIssued == dutStores)
		else
		begin
			endErrors++;
			$display("store count mismatch: %0d stores issued, %0d stores seen",
				storesIssued, dutStores);
		end
		$display("%0d checks, %0d errors", checkCount, errorCount + endErrors);
		if (errorCount + endErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("timeout: the run did not end within %0d clock cycles", WatchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== hdl/FprSlice.sv ====
// FPR slice top level.
// Two-stage pipeline: decode and register read feed execute, whose
// write-back struct returns to the register file write port.

module FprSlice
(
	input  logic                             clock,
	input  logic                             reset,

	input  logic [FprPkg::FprWordWidth-1:0]  opWord,
	input  logic                             opValid,
	input  logic                             hold,

	output logic                             storeValid,
	output logic [FprPkg::FprDataWidth-1:0]  storeData,
	output logic                             tBit
);

	import FprPkg::*;

	FprDecoded               decoded;
	FprWriteBack             writeBack;
	logic [FprDataWidth-1:0] valRm;
	logic [FprDataWidth-1:0] valRn;

	FprDecode u_FprDecode
	(
		.opWord   (opWord),
		.opValid  (opValid),
		.decoded  (decoded)
	);

	FprRegFile u_FprRegFile
	(
		.clock     (clock),
		.hold      (hold),
		.idRm      (decoded.rmId),
		.valRm     (valRm),
		.idRn      (decoded.rnId),
		.valRn     (valRn),
		.writeBack (writeBack)
	);

	FprExecute u_FprExecute
	(
		.clock      (clock),
		.reset      (reset),
		.hold       (hold),
		.decoded    (decoded),
		.valRm      (valRm),
		.valRn      (valRn),
		.writeBack  (writeBack),
		.storeValid (storeValid),
		.storeData  (storeData),
		.tBit       (tBit)
	);

endmodule

// ==== hdl/FprExecute.sv ====
// FPR execute stage.
// Bit-pattern operations on sign and magnitude plus a sign-magnitude
// comparator, registered into the write-back struct, store and T flag.

module FprExecute
(
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             hold,

	input  FprPkg::FprDecoded                decoded,
	input  logic [FprPkg::FprDataWidth-1:0]  valRm,
	input  logic [FprPkg::FprDataWidth-1:0]  valRn,

	output FprPkg::FprWriteBack              writeBack,
	output logic                             storeValid,
	output logic [FprPkg::FprDataWidth-1:0]  storeData,
	output logic                             tBit
);

	import FprPkg::*;

	localparam int MagWidth = FprDataWidth - 1;

	logic [FprDataWidth-1:0] result;
	logic [MagWidth-1:0]     magRm;
	logic [MagWidth-1:0]     magRn;
	logic                    signRm;
	logic                    signRn;
	logic                    isEq;
	logic                    isGt;
	logic                    isCompare;
	logic                    isStore;

	always_comb
	begin
		case (decoded.opcode)
			OpMov:   result = valRm;
			OpNeg:   result = {~valRm[FprDataWidth-1], valRm[MagWidth-1:0]};
			OpAbs:   result = {1'b0, valRm[MagWidth-1:0]};
			OpSgnj:  result = {valRn[FprDataWidth-1], valRm[MagWidth-1:0]};
			OpLdh:   result = {decoded.imm, {(FprDataWidth-FprImmWidth){1'b0}}};
			default: result = '0;
		endcase
	end

	// -0 folds to +0 so both zeros order as equal.
	assign magRm  = valRm[MagWidth-1:0];
	assign magRn  = valRn[MagWidth-1:0];
	assign signRm = valRm[FprDataWidth-1] && (magRm != '0);
	assign signRn = valRn[FprDataWidth-1] && (magRn != '0);

	assign isEq = (valRm == valRn) || ((magRm == '0) && (magRn == '0));

	always_comb
	begin
		if (signRm != signRn)
		begin
			isGt = !signRm;
		end
		else if (signRm)
		begin
			isGt = (magRm < magRn); // both negative.
		end
		else
		begin
			isGt = (magRm > magRn);
		end
	end

	assign isCompare = (decoded.opcode == OpCmpEq) || (decoded.opcode == OpCmpGt);
	assign isStore   = (decoded.opcode == OpStore);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writeBack.id    <= FprZeroId;
			writeBack.value <= '0;
			storeValid      <= 1'b0;
			tBit            <= 1'b0;
		end
		else if (!hold)
		begin
			writeBack.id    <= decoded.writes ? decoded.dstId : FprZeroId;
			writeBack.value <= decoded.writes ? result : '0; // idle forwards zero.
			storeValid      <= isStore;
			if (isCompare)
			begin
				tBit <= (decoded.opcode == OpCmpEq) ? isEq : isGt;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold && isStore)
		begin
			storeData <= valRn;
		end
	end

endmodule

// ==== hdl/FprDecode.sv ====
// FPR operation decoder.
// Splits a 32-bit operation word into its fields; invalid words and
// unknown opcodes become no-ops that write nothing.

module FprDecode
(
	input  logic [FprPkg::FprWordWidth-1:0]  opWord,
	input  logic                             opValid,
	output FprPkg::FprDecoded                decoded
);

	import FprPkg::*;

	logic [FprOpWidth-1:0] opRaw;
	logic [FprIdWidth-1:0] dstId;
	logic                  dstInRange;
	FprOpcode              opcode;

	assign opRaw = opWord[31:28];
	assign dstId = opWord[27:21];
	assign dstInRange = (dstId[FprIdWidth-1:FprIndexWidth] == '0);

	always_comb
	begin
		case (opRaw)
			OpMov, OpNeg, OpAbs, OpSgnj, OpLdh, OpCmpEq, OpCmpGt, OpStore:
				opcode = FprOpcode'(opRaw);
			default:
				opcode = OpNop; // codes 9..15 and 0.
		endcase
		if (!opValid)
		begin
			opcode = OpNop;
		end
	end

	always_comb
	begin
		decoded.opcode = opcode;
		decoded.dstId  = dstId;
		decoded.rmId   = opWord[20:14];
		decoded.rnId   = opWord[13:7];
		decoded.imm    = opWord[20:5]; // shares bits with Rm and Rn.
		case (opcode)
			OpMov, OpNeg, OpAbs, OpSgnj, OpLdh:
				decoded.writes = dstInRange;
			default:
				decoded.writes = 1'b0;
		endcase
	end

endmodule

// ==== hdl/FprRegFile.sv ====
// FPR register file.
// Sixteen 64-bit registers, two combinational read ports with write-back
// forwarding, a zero register and one write port blocked by the hold.

module FprRegFile
(
	input  logic                              clock,
	input  logic                              hold,

	input  logic [FprPkg::FprIdWidth-1:0]     idRm,
	output logic [FprPkg::FprDataWidth-1:0]   valRm,
	input  logic [FprPkg::FprIdWidth-1:0]     idRn,
	output logic [FprPkg::FprDataWidth-1:0]   valRn,

	input  FprPkg::FprWriteBack               writeBack
);

	import FprPkg::*;

	logic [FprDataWidth-1:0] regArr [FprRegCount];
	logic                    writeInRange;

	// one read port; forwarding wins over the array and the zero register.
	function automatic logic [FprDataWidth-1:0] readPort
	(
		input logic [FprIdWidth-1:0] id
	);
		logic [FprDataWidth-1:0] val;

		if (id == writeBack.id)
		begin
			val = writeBack.value;
		end
		else if (id == FprZeroId)
		begin
			val = '0;
		end
		else if (id[FprIdWidth-1:FprIndexWidth] == '0)
		begin
			val = regArr[id[FprIndexWidth-1:0]];
		end
		else
		begin
			val = 'x; // no such register.
		end
		return val;
	endfunction

	always_comb
	begin
		valRm = readPort(idRm);
	end

	always_comb
	begin
		valRn = readPort(idRn);
	end

	assign writeInRange = (writeBack.id[FprIdWidth-1:FprIndexWidth] == '0);

	// contents are not cleared by reset.
	always_ff @(posedge clock)
	begin
		if (!hold && writeInRange)
		begin
			regArr[writeBack.id[FprIndexWidth-1:0]] <= writeBack.value;
		end
	end

endmodule

// ==== hdl/FprPkg.sv ====
// FPR slice package.
// Widths, register ids, the opcode set and the structs passed between
// decode, register file and execute.

package FprPkg;

	localparam int FprDataWidth = 64;
	localparam int FprIdWidth = 7;
	localparam int FprIndexWidth = 4; // low id bits that select an entry.
	localparam int FprRegCount = 1 << FprIndexWidth;
	localparam int FprImmWidth = 16;
	localparam int FprOpWidth = 4;
	localparam int FprWordWidth = 32;

	// reads as zero, also the idle write-back id.
	localparam logic [FprIdWidth-1:0] FprZeroId = 7'h7F;

	typedef enum logic [FprOpWidth-1:0]
	{
		OpNop   = 4'h0,
		OpMov   = 4'h1,
		OpNeg   = 4'h2,
		OpAbs   = 4'h3,
		OpSgnj  = 4'h4, // magnitude of Rm, sign of Rn.
		OpLdh   = 4'h5, // immediate into the top 16 bits.
		OpCmpEq = 4'h6,
		OpCmpGt = 4'h7,
		OpStore = 4'h8
	} FprOpcode;

	// one decoded operation word.
	typedef struct packed
	{
		FprOpcode                opcode;
		logic [FprIdWidth-1:0]   dstId;
		logic [FprIdWidth-1:0]   rmId;
		logic [FprIdWidth-1:0]   rnId;
		logic [FprImmWidth-1:0]  imm;
		logic                    writes; // set only for a real register write.
	} FprDecoded;

	// write-back stage output, also the register file write port.
	typedef struct packed
	{
		logic [FprIdWidth-1:0]   id;
		logic [FprDataWidth-1:0] value;
	} FprWriteBack;

endpackage
